// ==== verilog.f ====
design/pixel_readout_pkg.sv
design/word_src_if.sv
design/word_fifo.sv
design/sr_capture.sv
design/hit_tdc.sv
design/readout_arbiter.sv
design/pixel_readout.sv
tb/tb_pixel_readout.sv

// ==== Bender.yml ====
package:
  name: pixel_readout

sources:
  - design/pixel_readout_pkg.sv
  - design/word_src_if.sv
  - design/word_fifo.sv
  - design/sr_capture.sv
  - design/hit_tdc.sv
  - design/readout_arbiter.sv
  - design/pixel_readout.sv
  - target: test
    files:
      - tb/tb_pixel_readout.sv

// ==== tb/tb_pixel_readout.sv ====
// pixel readout testbench
// random shift-register frames and hit pulses against per-source
// reference queues, output words checked by concurrent assertions
`timescale 1ns/1ps
`default_nettype none

module tb_pixel_readout;

    localparam int CLK_PERIOD = 10;
    localparam int WAIT_LIMIT = 5000;
    localparam int HELD_WORDS = 1 + pixel_readout_pkg::SR_FIFO_DEPTH
                              + pixel_readout_pkg::TDC_FIFO_DEPTH;

    logic                                 bus_clk = 1'b0;
    logic                                 rst_n;
    logic                                 sdi;
    logic                                 sen;
    logic                                 hit_or;
    logic                                 out_read;
    wire                                  out_empty;
    wire [pixel_readout_pkg::WORD_W-1:0]  out_data;
    wire [pixel_readout_pkg::LOST_W-1:0]  lost_words;

    // expected words per source, oldest first
    logic [31:0]                          sr_q [$];
    logic [31:0]                          tdc_q [$];
    logic [31:0]                          sr_head;
    logic [31:0]                          tdc_head;
    logic                                 sr_avail;
    logic                                 tdc_avail;
    logic [pixel_readout_pkg::CNT_W-1:0]  sr_seq;
    logic [pixel_readout_pkg::CNT_W-1:0]  tdc_seq;
    int                                   produced;
    int                                   received;
    string                                test_name;
    logic                                 id_known;
    logic                                 head_avail;
    logic [31:0]                          head_word;

    always #(CLK_PERIOD / 2) bus_clk = ~bus_clk;

    pixel_readout i_dut (
        .bus_clk   (bus_clk),
        .rst_n     (rst_n),
        .sdi       (sdi),
        .sen       (sen),
        .hit_or    (hit_or),
        .out_read  (out_read),
        .out_empty (out_empty),
        .out_data  (out_data),
        .lost_words(lost_words)
    );

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("** Error [%s]: expected %h, actual %h", name, expected, actual);
        stop_run();
    endtask

    task automatic report_plain(input string what);
        $display("[%s] %s", test_name, what);
        stop_run();
    endtask

    function automatic void refresh_heads();
        sr_avail  = (sr_q.size() != 0);
        tdc_avail = (tdc_q.size() != 0);
        sr_head   = sr_avail ? sr_q[0] : '0;
        tdc_head  = tdc_avail ? tdc_q[0] : '0;
    endfunction

    task automatic next_cycle();
        @(posedge bus_clk);
        #1;
    endtask

    // msb first, one bit per cycle, partial group at the end is lost
    task automatic shift_frame(input int groups, input int extra_bits);
        logic [15:0] payload;
        sen = 1'b1;
        for (int g = 0; g < groups; g++) begin
            payload = 16'($urandom);
            for (int b = 15; b >= 0; b--) begin
                sdi = payload[b];
                next_cycle();
            end
            sr_q.push_back({pixel_readout_pkg::SR_ID, sr_seq, payload});
            sr_seq++;
            produced++;
            refresh_heads();
        end
        for (int b = 0; b < extra_bits; b++) begin
            sdi = 1'($urandom);
            next_cycle();
        end
        sen = 1'b0;
        sdi = 1'b0;
        next_cycle();
    endtask

    task automatic hit_pulse(input int width, input int gap);
        hit_or = 1'b1;
        repeat (width) next_cycle();
        hit_or = 1'b0;
        tdc_q.push_back({pixel_readout_pkg::TDC_ID, tdc_seq, 16'(width)});
        tdc_seq++;
        produced++;
        refresh_heads();
        repeat (gap) next_cycle();
    endtask

    task automatic random_hits(input int count);
        for (int i = 0; i < count; i++) begin
            hit_pulse(int'($urandom % 40) + 1, int'($urandom % 4) + 2);
        end
    endtask

    task automatic wait_queues_empty();
        int cycles;
        cycles = 0;
        while (sr_q.size() != 0 || tdc_q.size() != 0) begin
            if (cycles >= WAIT_LIMIT) begin
                report_plain("expected words never came out");
            end else begin
                cycles++;
                next_cycle();
            end
        end
    endtask

    task automatic wait_drained(input int quiet);
        int cycles;
        int idle;
        cycles = 0;
        idle   = 0;
        while (idle < quiet) begin
            if (cycles >= WAIT_LIMIT) begin
                report_plain("output register did not drain");
            end else begin
                idle = out_empty ? idle + 1 : 0;
                cycles++;
                next_cycle();
            end
        end
    endtask

    // pick the reference head by the word's source id
    always @* begin
        id_known   = 1'b1;
        head_avail = 1'b0;
        head_word  = '0;
        case (out_data[31:28])
            pixel_readout_pkg::SR_ID: begin
                head_avail = sr_avail;
                head_word  = sr_head;
            end
            pixel_readout_pkg::TDC_ID: begin
                head_avail = tdc_avail;
                head_word  = tdc_head;
            end
            default: id_known = 1'b0;
        endcase
    end

    always @(posedge bus_clk) begin
        if (rst_n && out_read && !out_empty) begin
            received++;
            if (out_data[31:28] == pixel_readout_pkg::SR_ID && sr_q.size() != 0) begin
                void'(sr_q.pop_front());
            end else if (out_data[31:28] == pixel_readout_pkg::TDC_ID && tdc_q.size() != 0) begin
                void'(tdc_q.pop_front());
            end
            refresh_heads();
        end
    end

    a_known_id: assert property (
        @(posedge bus_clk) disable iff (!rst_n) (out_read && !out_empty) |-> id_known
    ) else report_plain("output word carries an unknown source id");

    a_word_expected: assert property (
        @(posedge bus_clk) disable iff (!rst_n) (out_read && !out_empty) |-> head_avail
    ) else report_plain("output word arrived while none was expected from its source");

    a_word_value: assert property (
        @(posedge bus_clk) disable iff (!rst_n)
        (out_read && !out_empty) |-> (out_data == head_word)
    ) else report_value(test_name, $sampled(head_word), $sampled(out_data));

    initial begin
        int phase_start;
        void'($urandom(14467));
        rst_n     = 1'b0;
        sdi       = 1'b0;
        sen       = 1'b0;
        hit_or    = 1'b0;
        out_read  = 1'b0;
        sr_seq    = '0;
        tdc_seq   = '0;
        produced  = 0;
        received  = 0;
        test_name = "reset_state";
        refresh_heads();
        repeat (8) @(posedge bus_clk);
        #1;
        rst_n = 1'b1;

        repeat (4) begin
            next_cycle();
            assert (out_empty === 1'b1) else report_value(test_name, 32'd1, 32'(out_empty));
            assert (lost_words === '0) else report_value(test_name, 32'd0, 32'(lost_words));
        end

        test_name = "shift_register";
        out_read  = 1'b1;
        shift_frame(3, 0);
        shift_frame(2, 7);
        shift_frame(2, 0);
        wait_queues_empty();

        test_name = "hit_timing";
        random_hits(10);
        wait_queues_empty();

        test_name = "both_sources";
        fork
            begin
                shift_frame(4, 5);
                shift_frame(3, 0);
            end
            random_hits(12);
        join
        wait_queues_empty();

        // more words than register and both fifos hold
        test_name   = "back_pressure";
        out_read    = 1'b0;
        phase_start = received;
        fork
            shift_frame(12, 0);
            random_hits(8);
        join
        repeat (4) next_cycle();
        out_read = 1'b1;
        wait_drained(20);
        assert (received - phase_start == HELD_WORDS)
            else report_value(test_name, 32'(HELD_WORDS), 32'(received - phase_start));
        assert (32'(lost_words) == 32'(produced - received))
            else report_value(test_name, 32'(produced - received), 32'(lost_words));

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/pixel_readout.sv ====
// pixel readout top level
// shift-register capture and hit tdc feeding one merged output register
`timescale 1ns/1ps
`default_nettype none

module pixel_readout (
    input wire                                  bus_clk,
    input wire                                  rst_n,
    input wire                                  sdi,
    input wire                                  sen,
    input wire                                  hit_or,
    input wire                                  out_read,
    output wire                                 out_empty,
    output wire [pixel_readout_pkg::WORD_W-1:0] out_data,
    output wire [pixel_readout_pkg::LOST_W-1:0] lost_words
);

    word_src_if sr_if ();
    word_src_if tdc_if ();

    sr_capture i_sr_capture (
        .bus_clk(bus_clk),
        .rst_n  (rst_n),
        .sdi    (sdi),
        .sen    (sen),
        .src    (sr_if.source)
    );

    hit_tdc i_hit_tdc (
        .bus_clk(bus_clk),
        .rst_n  (rst_n),
        .hit_or (hit_or),
        .src    (tdc_if.source)
    );

    readout_arbiter i_readout_arbiter (
        .bus_clk   (bus_clk),
        .rst_n     (rst_n),
        .sr        (sr_if.sink),
        .tdc       (tdc_if.sink),
        .out_read  (out_read),
        .out_empty (out_empty),
        .out_data  (out_data),
        .lost_words(lost_words)
    );

endmodule

`default_nettype wire

// ==== design/readout_arbiter.sv ====
// readout arbiter
// merges the shift-register and tdc word streams round robin into a
// single output register and counts words dropped at the source fifos
`timescale 1ns/1ps
`default_nettype none

module readout_arbiter (
    input wire                                   bus_clk,
    input wire                                   rst_n,
    word_src_if.sink                             sr,
    word_src_if.sink                             tdc,
    input wire                                   out_read,
    output logic                                 out_empty,
    output logic [pixel_readout_pkg::WORD_W-1:0] out_data,
    output logic [pixel_readout_pkg::LOST_W-1:0] lost_words
);

    pixel_readout_pkg::grant_e             last_grant;
    logic                                  can_load;
    logic                                  sr_pend;
    logic                                  tdc_pend;
    logic [pixel_readout_pkg::LOST_W:0]    lost_sum;

    // register is free, or its word leaves this cycle
    assign can_load = out_empty || out_read;
    assign sr_pend  = !sr.empty;
    assign tdc_pend = !tdc.empty;

    assign lost_sum = {1'b0, lost_words}
                    + (pixel_readout_pkg::LOST_W + 1)'(sr.dropped)
                    + (pixel_readout_pkg::LOST_W + 1)'(tdc.dropped);

    always_comb begin
        sr.read  = 1'b0;
        tdc.read = 1'b0;
        if (can_load) begin
            if (sr_pend && tdc_pend) begin
                // both waiting, serve the other one
                if (last_grant == pixel_readout_pkg::GRANT_SR) begin
                    tdc.read = 1'b1;
                end else begin
                    sr.read = 1'b1;
                end
            end else if (sr_pend) begin
                sr.read = 1'b1;
            end else if (tdc_pend) begin
                tdc.read = 1'b1;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (sr.read) begin
            out_data <= sr.data;
        end else if (tdc.read) begin
            out_data <= tdc.data;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            out_empty  <= 1'b1;
            last_grant <= pixel_readout_pkg::GRANT_TDC;
            lost_words <= '0;
        end else begin
            if (sr.read) begin
                out_empty  <= 1'b0;
                last_grant <= pixel_readout_pkg::GRANT_SR;
            end else if (tdc.read) begin
                out_empty  <= 1'b0;
                last_grant <= pixel_readout_pkg::GRANT_TDC;
            end else if (out_read) begin
                out_empty <= 1'b1;
            end
            // saturating drop count
            if (lost_sum[pixel_readout_pkg::LOST_W]) begin
                lost_words <= '1;
            end else begin
                lost_words <= lost_sum[pixel_readout_pkg::LOST_W-1:0];
            end
        end
    end

    a_one_grant: assert property (
        @(posedge bus_clk) disable iff (!rst_n) !(sr.read && tdc.read)
    );

endmodule

`default_nettype wire

// ==== design/hit_tdc.sv ====
// hit pulse width measurement
// counts the cycles hit_or is sampled high and emits one tagged word
// per hit carrying the hit counter and the saturated width
`timescale 1ns/1ps
`default_nettype none

module hit_tdc (
    input wire         bus_clk,
    input wire         rst_n,
    input wire         hit_or,
    word_src_if.source src
);

    pixel_readout_pkg::tdc_state_e           state;
    logic [pixel_readout_pkg::PAYLOAD_W-1:0] width;
    logic [pixel_readout_pkg::CNT_W-1:0]     hit_cnt;
    logic [pixel_readout_pkg::CNT_W-1:0]     cnt_now;
    logic                                    word_wr;
    logic [pixel_readout_pkg::WORD_W-1:0]    word_data;
    logic                                    wr_d;

    assign cnt_now = hit_cnt + pixel_readout_pkg::CNT_W'(wr_d && !src.dropped);

    always_ff @(posedge bus_clk) begin
        if (state == pixel_readout_pkg::TDC_IDLE) begin
            width <= pixel_readout_pkg::PAYLOAD_W'(1);
        end else if (hit_or && width != '1) begin
            width <= width + 1'b1;
        end
        if (state == pixel_readout_pkg::TDC_MEASURE && !hit_or) begin
            word_data <= {pixel_readout_pkg::TDC_ID, cnt_now, width};
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            state   <= pixel_readout_pkg::TDC_IDLE;
            word_wr <= 1'b0;
            hit_cnt <= '0;
            wr_d    <= 1'b0;
        end else begin
            wr_d    <= word_wr;
            hit_cnt <= cnt_now;
            word_wr <= 1'b0;
            case (state)
                pixel_readout_pkg::TDC_IDLE: begin
                    if (hit_or) begin
                        state <= pixel_readout_pkg::TDC_MEASURE;
                    end
                end
                pixel_readout_pkg::TDC_MEASURE: begin
                    // hit has ended
                    if (!hit_or) begin
                        state   <= pixel_readout_pkg::TDC_IDLE;
                        word_wr <= 1'b1;
                    end
                end
                default: state <= pixel_readout_pkg::TDC_IDLE;
            endcase
        end
    end

    word_fifo #(
        .DEPTH(pixel_readout_pkg::TDC_FIFO_DEPTH)
    ) i_tdc_fifo (
        .bus_clk(bus_clk),
        .rst_n  (rst_n),
        .wr     (word_wr),
        .wr_data(word_data),
        .src    (src)
    );

    a_width_monotonic: assert property (
        @(posedge bus_clk) disable iff (!rst_n)
        (state == pixel_readout_pkg::TDC_MEASURE && hit_or) |=> (width >= $past(width))
    );

endmodule

`default_nettype wire

// ==== design/sr_capture.sv ====
// pixel shift-register capture
// samples sdi while sen is high, msb first, and packs each 16-bit group
// into a word tagged with the shift-register id and a running counter
`timescale 1ns/1ps
`default_nettype none

module sr_capture (
    input wire         bus_clk,
    input wire         rst_n,
    input wire         sdi,
    input wire         sen,
    word_src_if.source src
);

    logic [pixel_readout_pkg::PAYLOAD_W-1:0] shift_reg;
    logic [3:0]                              bit_cnt;
    logic                                    word_wr;
    logic [pixel_readout_pkg::WORD_W-1:0]    word_data;
    logic [pixel_readout_pkg::CNT_W-1:0]     word_cnt;
    logic [pixel_readout_pkg::CNT_W-1:0]     cnt_now;
    logic                                    wr_d;

    // count a word once the fifo has shown it was not dropped
    assign cnt_now = word_cnt + pixel_readout_pkg::CNT_W'(wr_d && !src.dropped);

    always_ff @(posedge bus_clk) begin
        if (sen) begin
            shift_reg <= {shift_reg[pixel_readout_pkg::PAYLOAD_W-2:0], sdi};
        end
        if (sen && bit_cnt == 4'd15) begin
            word_data <= {pixel_readout_pkg::SR_ID, cnt_now,
                          shift_reg[pixel_readout_pkg::PAYLOAD_W-2:0], sdi};
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            bit_cnt  <= '0;
            word_wr  <= 1'b0;
            word_cnt <= '0;
            wr_d     <= 1'b0;
        end else begin
            wr_d     <= word_wr;
            word_cnt <= cnt_now;
            // 16th bit completes a word
            word_wr  <= sen && (bit_cnt == 4'd15);
            if (sen) begin
                bit_cnt <= bit_cnt + 1'b1;
            end else begin
                // partial group is thrown away
                bit_cnt <= '0;
            end
        end
    end

    word_fifo #(
        .DEPTH(pixel_readout_pkg::SR_FIFO_DEPTH)
    ) i_sr_fifo (
        .bus_clk(bus_clk),
        .rst_n  (rst_n),
        .wr     (word_wr),
        .wr_data(word_data),
        .src    (src)
    );

    a_frame_restart: assert property (
        @(posedge bus_clk) disable iff (!rst_n) !sen |=> (bit_cnt == '0)
    );

endmodule

`default_nettype wire

// ==== design/word_fifo.sv ====
// word fifo
// synchronous circular buffer for readout words, first-word fall-through;
// a write while full is discarded and flagged with a one-cycle drop pulse
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
    parameter int DEPTH = 8
) (
    input wire                                 bus_clk,
    input wire                                 rst_n,
    input wire                                 wr,
    input wire [pixel_readout_pkg::WORD_W-1:0] wr_data,
    word_src_if.source                         src
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int OCC_W = $clog2(DEPTH + 1);

    logic [pixel_readout_pkg::WORD_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]                     rd_ptr;
    logic [PTR_W-1:0]                     wr_ptr;
    logic [OCC_W-1:0]                     occ;
    logic                                 full;
    logic                                 push;
    logic                                 pop;
    logic                                 dropped_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full        = (occ == OCC_W'(DEPTH));
    assign push        = wr && !full;
    assign pop         = src.read && !src.empty;
    assign src.empty   = (occ == '0);
    assign src.data    = mem[rd_ptr];
    assign src.dropped = dropped_q;

    always_ff @(posedge bus_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            occ       <= '0;
            dropped_q <= 1'b0;
        end else begin
            // full fifo keeps its contents, new word is lost
            dropped_q <= wr && full;
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

    // the arbiter must only pop a word that is there
    a_no_read_when_empty: assert property (
        @(posedge bus_clk) disable iff (!rst_n) !(src.read && src.empty)
    );

endmodule

`default_nettype wire

// ==== design/word_src_if.sv ====
// word source interface
// carries one source's buffered words and drop pulses to the arbiter
`timescale 1ns/1ps
`default_nettype none

interface word_src_if;

    logic                                 empty;
    logic                                 read;
    logic [pixel_readout_pkg::WORD_W-1:0] data;
    logic                                 dropped;

    // fifo side
    modport source (
        output empty,
        output data,
        output dropped,
        input  read
    );

    // arbiter side
    modport sink (
        input  empty,
        input  data,
        input  dropped,
        output read
    );

endinterface

`default_nettype wire

// ==== design/pixel_readout_pkg.sv ====
// pixel readout shared definitions
// word layout, source identifiers, buffer depths and state encodings
`default_nettype none

package pixel_readout_pkg;

    // readout word: id[31:28], sequence counter[27:16], payload[15:0]
    localparam int WORD_W    = 32;
    localparam int ID_W      = 4;
    localparam int CNT_W     = 12;
    localparam int PAYLOAD_W = 16;

    localparam logic [ID_W-1:0] SR_ID  = 4'b0001;
    localparam logic [ID_W-1:0] TDC_ID = 4'b0100;

    localparam int SR_FIFO_DEPTH  = 8;
    localparam int TDC_FIFO_DEPTH = 4;

    // drop counter, saturates
    localparam int LOST_W = 8;

    typedef enum logic {
        TDC_IDLE,
        TDC_MEASURE
    } tdc_state_e;

    // last source served by the arbiter
    typedef enum logic {
        GRANT_SR,
        GRANT_TDC
    } grant_e;

endpackage

`default_nettype wire
